// File: atop_config.svh
`ifndef ATOP_CONFIG_SVH
`define ATOP_CONFIG_SVH

// Transaction ID width on both ports
`define ATOP_ID_WIDTH 4

// Address width of the write channel
`define ATOP_ADDR_WIDTH 16

// Data width of W and R beats
`define ATOP_DATA_WIDTH 32

// Write bursts allowed in flight downstream
// at the same time
`define ATOP_MAX_WRITE_TXNS 4

`endif

// File: atop_pkg.sv
`include "atop_config.svh"

package atop_pkg;

  // Basic AXI field types
  typedef logic [`ATOP_ID_WIDTH-1:0]   id_t;
  typedef logic [`ATOP_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`ATOP_DATA_WIDTH-1:0] data_t;
  typedef logic [7:0]                  len_t;
  typedef logic [5:0]                  atop_t;

  // AXI response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  // Atop bit that asks for an R response
  localparam int unsigned ATOP_R_RESP_BIT = 5;
  // Atop[5:4] value of a plain write
  localparam logic [1:0] ATOP_NONE = 2'b00;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_beat_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_beat_t;

endpackage

// File: err_cmd_if.sv
`timescale 1ns/1ps

interface err_cmd_if;
  import atop_pkg::*;

  // One-cycle request for an R error burst
  logic cmd_valid;
  id_t  cmd_id;
  len_t cmd_len;
  // Generator still has beats to send
  logic busy;

  modport ctrl (
    output cmd_valid, cmd_id, cmd_len,
    input  busy
  );

  modport gen (
    input  cmd_valid, cmd_id, cmd_len,
    output busy
  );
endinterface

// File: w_burst_tracker.sv
`timescale 1ns/1ps
`include "atop_config.svh"

module w_burst_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic m_aw_valid_i,
  input  logic m_aw_ready_i,
  input  logic m_w_valid_i,
  input  logic m_w_ready_i,
  input  logic m_w_last_i,
  output logic aw_pending_o,
  output logic w_ahead_o,
  output logic aw_room_o
);
  localparam int unsigned MAX_TXNS = `ATOP_MAX_WRITE_TXNS;
  // Two bits at least, so that minus one can be told apart from the limit
  localparam int unsigned CNT_WIDTH = (MAX_TXNS == 1) ? 2 : $clog2(MAX_TXNS + 1);

  logic [CNT_WIDTH-1:0] cnt_d, cnt_q;
  logic                 uflow_d, uflow_q;
  logic                 aw_hs, w_last_hs;

  assign aw_hs     = m_aw_valid_i && m_aw_ready_i;
  assign w_last_hs = m_w_valid_i && m_w_ready_i && m_w_last_i;

  // AW downstream still waiting for its last W beat
  assign aw_pending_o = !uflow_q && (cnt_q != '0);
  // Count sits at minus one, a whole W burst went first
  assign w_ahead_o    = uflow_q && (&cnt_q);
  assign aw_room_o    = w_ahead_o || (!uflow_q && (cnt_q < CNT_WIDTH'(MAX_TXNS)));

  always_comb begin
    cnt_d   = cnt_q;
    uflow_d = uflow_q;
    if (aw_hs) begin
      cnt_d = cnt_d + 1'b1;
    end
    if (w_last_hs) begin
      cnt_d = cnt_d - 1'b1;
    end
    // Leave minus one once the late AW shows up
    if (uflow_q && (cnt_d == '0)) begin
      uflow_d = 1'b0;
    end else if ((cnt_q == '0) && (&cnt_d)) begin
      uflow_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      uflow_q <= 1'b0;
    end else begin
      cnt_q   <= cnt_d;
      uflow_q <= uflow_d;
    end
  end
endmodule

// File: write_ctrl.sv
`timescale 1ns/1ps

module write_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              s_aw_valid_i,
  input  atop_pkg::id_t     s_aw_id_i,
  input  atop_pkg::len_t    s_aw_len_i,
  input  atop_pkg::atop_t   s_aw_atop_i,
  output logic              s_aw_ready_o,
  input  logic              s_w_valid_i,
  input  logic              s_w_last_i,
  output logic              s_w_ready_o,
  output logic              m_aw_valid_o,
  input  logic              m_aw_ready_i,
  output logic              m_w_valid_o,
  input  logic              m_w_ready_i,
  input  logic              aw_pending_i,
  input  logic              w_ahead_i,
  input  logic              aw_room_i,
  output logic              b_inj_valid_o,
  input  logic              b_inj_ready_i,
  output atop_pkg::b_beat_t b_inj_o,
  err_cmd_if.ctrl           cmd
);
  import atop_pkg::*;

  typedef enum logic [2:0] {
    W_RESET, W_FEED, W_BLOCK_AW, W_ABSORB_W, W_INJECT_B, W_WAIT_R
  } w_state_e;

  w_state_e w_state_d, w_state_q;
  id_t      id_d, id_q;
  logic     aw_atop, aw_plain;

  assign aw_atop  = s_aw_valid_i && (s_aw_atop_i[5:4] != ATOP_NONE);
  assign aw_plain = s_aw_valid_i && (s_aw_atop_i[5:4] == ATOP_NONE);

  // R command fields follow the AW being absorbed
  assign cmd.cmd_id  = s_aw_id_i;
  assign cmd.cmd_len = s_aw_len_i;

  // Error B always answers the stored atomic ID
  assign b_inj_o = '{id: id_q, resp: RESP_SLVERR};

  always_comb begin
    s_aw_ready_o  = 1'b0;
    m_aw_valid_o  = 1'b0;
    s_w_ready_o   = 1'b0;
    m_w_valid_o   = 1'b0;
    b_inj_valid_o = 1'b0;
    cmd.cmd_valid = 1'b0;
    id_d          = id_q;
    w_state_d     = w_state_q;

    unique case (w_state_q)
      W_RESET: w_state_d = W_FEED;

      W_FEED: begin
        // AW passes while the outstanding limit allows it
        if (aw_room_i) begin
          m_aw_valid_o = s_aw_valid_i;
          s_aw_ready_o = m_aw_ready_i;
        end
        // W passes for a known AW, or alongside a plain AW unless a burst is already ahead
        if (aw_pending_i || (aw_plain && !w_ahead_i)) begin
          m_w_valid_o = s_w_valid_i;
          s_w_ready_o = m_w_ready_i;
        end
        if (aw_atop) begin
          // Swallow the atomic AW here
          m_aw_valid_o = 1'b0;
          s_aw_ready_o = 1'b1;
          id_d         = s_aw_id_i;
          if (s_aw_atop_i[ATOP_R_RESP_BIT]) begin
            cmd.cmd_valid = 1'b1;
          end
          if (aw_pending_i) begin
            // Earlier bursts still own the next W beats
            w_state_d = W_BLOCK_AW;
          end else begin
            m_w_valid_o = 1'b0;
            s_w_ready_o = 1'b1;
            if (s_w_valid_i && s_w_last_i) begin
              w_state_d = W_INJECT_B;
            end else begin
              w_state_d = W_ABSORB_W;
            end
          end
        end
      end

      W_BLOCK_AW: begin
        if (aw_pending_i) begin
          m_w_valid_o = s_w_valid_i;
          s_w_ready_o = m_w_ready_i;
        end else begin
          // Drained, the next W burst belongs to the atomic
          s_w_ready_o = 1'b1;
          if (s_w_valid_i && s_w_last_i) begin
            w_state_d = W_INJECT_B;
          end else begin
            w_state_d = W_ABSORB_W;
          end
        end
      end

      W_ABSORB_W: begin
        s_w_ready_o = 1'b1;
        if (s_w_valid_i && s_w_last_i) begin
          w_state_d = W_INJECT_B;
        end
      end

      W_INJECT_B: begin
        // Arbiter holds this off while a downstream B is stuck upstream
        b_inj_valid_o = 1'b1;
        if (b_inj_ready_i) begin
          w_state_d = cmd.busy ? W_WAIT_R : W_FEED;
        end
      end

      W_WAIT_R: begin
        // Stay until the R error burst has gone out
        if (!cmd.busy) begin
          w_state_d = W_FEED;
        end
      end

      default: w_state_d = W_RESET;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q <= W_RESET;
    end else begin
      w_state_q <= w_state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    id_q <= id_d;
  end
endmodule

// File: r_err_gen.sv
`timescale 1ns/1ps

module r_err_gen (
  input  logic              clk_i,
  input  logic              rst_ni,
  err_cmd_if.gen            cmd,
  output logic              inj_valid_o,
  input  logic              inj_ready_i,
  output atop_pkg::r_beat_t inj_o
);
  import atop_pkg::*;

  logic busy_q;
  len_t beats_q;
  id_t  id_q;
  logic last_beat;

  // Beats left after the current one
  assign last_beat = (beats_q == '0);

  assign cmd.busy    = busy_q;
  assign inj_valid_o = busy_q;
  assign inj_o       = '{id: id_q, data: '0, resp: RESP_SLVERR, last: last_beat};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      beats_q <= '0;
    end else if (cmd.cmd_valid) begin
      // Burst of len+1 beats starts next cycle
      busy_q  <= 1'b1;
      beats_q <= cmd.cmd_len;
    end else if (busy_q && inj_ready_i) begin
      if (last_beat) begin
        busy_q <= 1'b0;
      end else begin
        beats_q <= beats_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd.cmd_valid) begin
      id_q <= cmd.cmd_id;
    end
  end
endmodule

// File: resp_arbiter.sv
`timescale 1ns/1ps

module resp_arbiter #(
  parameter type beat_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  dn_valid_i,
  output logic  dn_ready_o,
  input  beat_t dn_i,
  input  logic  inj_valid_i,
  output logic  inj_ready_o,
  input  beat_t inj_i,
  output logic  up_valid_o,
  input  logic  up_ready_i,
  output beat_t up_o
);
  typedef enum logic [1:0] { ARB_FEED, ARB_HOLD_DN, ARB_INJECT } arb_state_e;

  arb_state_e state_d, state_q;
  logic       sel_inj;

  // Injected beats own the channel only while their source keeps valid up
  assign sel_inj = (state_q == ARB_INJECT) && inj_valid_i;

  assign up_valid_o  = sel_inj ? inj_valid_i : dn_valid_i;
  assign up_o        = sel_inj ? inj_i : dn_i;
  assign dn_ready_o  = sel_inj ? 1'b0 : up_ready_i;
  assign inj_ready_o = sel_inj ? up_ready_i : 1'b0;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ARB_HOLD_DN: begin
        // Offered downstream beat must finish first
        if (!dn_valid_i || up_ready_i) begin
          state_d = inj_valid_i ? ARB_INJECT : ARB_FEED;
        end
      end
      default: begin
        if (!sel_inj) begin
          // Feed, or injection finished
          if (dn_valid_i && !up_ready_i) begin
            state_d = ARB_HOLD_DN;
          end else if (inj_valid_i) begin
            state_d = ARB_INJECT;
          end else begin
            state_d = ARB_FEED;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ARB_FEED;
    end else begin
      state_q <= state_d;
    end
  end
endmodule

// File: atop_filter_top.sv
`timescale 1ns/1ps

module atop_filter_top (
  input  logic            clk_i,
  input  logic            rst_ni,
  // Upstream master side
  input  logic            s_aw_valid_i,
  output logic            s_aw_ready_o,
  input  atop_pkg::id_t   s_aw_id_i,
  input  atop_pkg::addr_t s_aw_addr_i,
  input  atop_pkg::len_t  s_aw_len_i,
  input  atop_pkg::atop_t s_aw_atop_i,
  input  logic            s_w_valid_i,
  output logic            s_w_ready_o,
  input  atop_pkg::data_t s_w_data_i,
  input  logic            s_w_last_i,
  output logic            s_b_valid_o,
  input  logic            s_b_ready_i,
  output atop_pkg::id_t   s_b_id_o,
  output atop_pkg::resp_e s_b_resp_o,
  output logic            s_r_valid_o,
  input  logic            s_r_ready_i,
  output atop_pkg::id_t   s_r_id_o,
  output atop_pkg::data_t s_r_data_o,
  output atop_pkg::resp_e s_r_resp_o,
  output logic            s_r_last_o,
  // Downstream slave side
  output logic            m_aw_valid_o,
  input  logic            m_aw_ready_i,
  output atop_pkg::id_t   m_aw_id_o,
  output atop_pkg::addr_t m_aw_addr_o,
  output atop_pkg::len_t  m_aw_len_o,
  output logic            m_w_valid_o,
  input  logic            m_w_ready_i,
  output atop_pkg::data_t m_w_data_o,
  output logic            m_w_last_o,
  input  logic            m_b_valid_i,
  output logic            m_b_ready_o,
  input  atop_pkg::id_t   m_b_id_i,
  input  atop_pkg::resp_e m_b_resp_i,
  input  logic            m_r_valid_i,
  output logic            m_r_ready_o,
  input  atop_pkg::id_t   m_r_id_i,
  input  atop_pkg::data_t m_r_data_i,
  input  atop_pkg::resp_e m_r_resp_i,
  input  logic            m_r_last_i
);
  import atop_pkg::*;

  logic    aw_pending, w_ahead, aw_room;
  logic    b_inj_valid, b_inj_ready, r_inj_valid, r_inj_ready;
  b_beat_t b_inj, m_b_beat, s_b_beat;
  r_beat_t r_inj, m_r_beat, s_r_beat;

  err_cmd_if u_cmd ();

  // Payloads go straight through, no atop downstream
  assign m_aw_id_o   = s_aw_id_i;
  assign m_aw_addr_o = s_aw_addr_i;
  assign m_aw_len_o  = s_aw_len_i;
  assign m_w_data_o  = s_w_data_i;
  assign m_w_last_o  = s_w_last_i;

  // Pack and unpack response beats for the arbiters
  assign m_b_beat = '{id: m_b_id_i, resp: m_b_resp_i};
  assign m_r_beat = '{id: m_r_id_i, data: m_r_data_i, resp: m_r_resp_i, last: m_r_last_i};
  assign s_b_id_o   = s_b_beat.id;
  assign s_b_resp_o = s_b_beat.resp;
  assign s_r_id_o   = s_r_beat.id;
  assign s_r_data_o = s_r_beat.data;
  assign s_r_resp_o = s_r_beat.resp;
  assign s_r_last_o = s_r_beat.last;

  w_burst_tracker u_tracker (
    .clk_i, .rst_ni,
    .m_aw_valid_i(m_aw_valid_o), .m_aw_ready_i, .m_w_valid_i(m_w_valid_o),
    .m_w_ready_i, .m_w_last_i(s_w_last_i),
    .aw_pending_o(aw_pending), .w_ahead_o(w_ahead), .aw_room_o(aw_room)
  );

  write_ctrl u_write_ctrl (
    .clk_i, .rst_ni,
    .s_aw_valid_i, .s_aw_id_i, .s_aw_len_i, .s_aw_atop_i, .s_aw_ready_o,
    .s_w_valid_i, .s_w_last_i, .s_w_ready_o,
    .m_aw_valid_o, .m_aw_ready_i, .m_w_valid_o, .m_w_ready_i,
    .aw_pending_i(aw_pending), .w_ahead_i(w_ahead), .aw_room_i(aw_room),
    .b_inj_valid_o(b_inj_valid), .b_inj_ready_i(b_inj_ready), .b_inj_o(b_inj),
    .cmd(u_cmd.ctrl)
  );

  r_err_gen u_r_err_gen (
    .clk_i, .rst_ni, .cmd(u_cmd.gen),
    .inj_valid_o(r_inj_valid), .inj_ready_i(r_inj_ready), .inj_o(r_inj)
  );

  resp_arbiter #(.beat_t(b_beat_t)) u_b_arb (
    .clk_i, .rst_ni,
    .dn_valid_i(m_b_valid_i), .dn_ready_o(m_b_ready_o), .dn_i(m_b_beat),
    .inj_valid_i(b_inj_valid), .inj_ready_o(b_inj_ready), .inj_i(b_inj),
    .up_valid_o(s_b_valid_o), .up_ready_i(s_b_ready_i), .up_o(s_b_beat)
  );

  resp_arbiter #(.beat_t(r_beat_t)) u_r_arb (
    .clk_i, .rst_ni,
    .dn_valid_i(m_r_valid_i), .dn_ready_o(m_r_ready_o), .dn_i(m_r_beat),
    .inj_valid_i(r_inj_valid), .inj_ready_o(r_inj_ready), .inj_i(r_inj),
    .up_valid_o(s_r_valid_o), .up_ready_i(s_r_ready_i), .up_o(s_r_beat)
  );
endmodule

// File: atop_filter_chk.sv
`timescale 1ns/1ps

module atop_filter_chk (
  input logic                                  clk_i,
  input logic                                  rst_ni,
  input logic                                  b_valid_i,
  input logic                                  b_ready_i,
  input logic [$bits(atop_pkg::b_beat_t)-1:0]  b_beat_i,
  input logic                                  r_valid_i,
  input logic                                  r_ready_i,
  input logic [$bits(atop_pkg::r_beat_t)-1:0]  r_beat_i,
  input logic                                  w_dn_valid_i,
  input logic                                  w_dn_ready_i,
  input logic                                  w_up_ready_i
);
  // Failed assertions, read back by the testbench
  int unsigned fail_cnt = 0;

  // Upstream B beat held until accepted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (b_valid_i && !b_ready_i) |=> (b_valid_i && $stable(b_beat_i)))
  else begin
    $error("Upstream B dropped valid or changed payload before ready");
    fail_cnt++;
  end

  // Same for upstream R
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_i && !r_ready_i) |=> (r_valid_i && $stable(r_beat_i)))
  else begin
    $error("Upstream R dropped valid or changed payload before ready");
    fail_cnt++;
  end

  // Downstream W only while upstream ready follows downstream ready
  // A forced upstream ready means absorption, then no W goes down
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_dn_valid_i |-> (w_up_ready_i == w_dn_ready_i))
  else begin
    $error("Downstream W valid while upstream W was being absorbed");
    fail_cnt++;
  end
endmodule

bind atop_filter_top atop_filter_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .b_valid_i    (s_b_valid_o),
  .b_ready_i    (s_b_ready_i),
  .b_beat_i     ({s_b_id_o, s_b_resp_o}),
  .r_valid_i    (s_r_valid_o),
  .r_ready_i    (s_r_ready_i),
  .r_beat_i     ({s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o}),
  .w_dn_valid_i (m_w_valid_o),
  .w_dn_ready_i (m_w_ready_i),
  .w_up_ready_i (s_w_ready_o)
);

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);
  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release reset just after the third rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end
endmodule

// File: tb_atop_filter.sv
`timescale 1ns/1ps
`include "atop_config.svh"

module tb_atop_filter;
  import atop_pkg::*;

  localparam int unsigned TIMEOUT = 100;
  localparam atop_t       ATOP_PLAIN = 6'b00_0000;
  // Atomic store, no read data back
  localparam atop_t       ATOP_STORE = 6'b01_0000;
  // Atomic load, bit 5 asks for R beats
  localparam atop_t       ATOP_LOAD  = 6'b10_0000;

  logic    clk_i, rst_n;
  logic    s_aw_valid_i, s_aw_ready_o, s_w_valid_i, s_w_ready_o, s_w_last_i;
  id_t     s_aw_id_i, s_b_id_o, s_r_id_o, m_aw_id_o, m_b_id_i, m_r_id_i;
  addr_t   s_aw_addr_i, m_aw_addr_o;
  len_t    s_aw_len_i, m_aw_len_o;
  atop_t   s_aw_atop_i;
  data_t   s_w_data_i, s_r_data_o, m_w_data_o, m_r_data_i;
  logic    s_b_valid_o, s_b_ready_i, s_r_valid_o, s_r_ready_i, s_r_last_o;
  resp_e   s_b_resp_o, s_r_resp_o, m_b_resp_i, m_r_resp_i;
  logic    m_aw_valid_o, m_aw_ready_i, m_w_valid_o, m_w_ready_i, m_w_last_o;
  logic    m_b_valid_i, m_b_ready_o, m_r_valid_i, m_r_ready_o, m_r_last_i;
  int      errors = 0;
  int      timeouts = 0;
  // Handshake counters, sampled at the falling edge
  int      dn_aw_cnt = 0;
  int      dn_w_cnt = 0;
  int      up_b_cnt = 0;
  int      up_r_cnt = 0;

  tb_clk_gen #(.RST_CYCLES(3)) u_clk_gen (.clk_o(clk_i), .rst_no(rst_n));

  atop_filter_top uut (
    .clk_i, .rst_ni(rst_n),
    .s_aw_valid_i, .s_aw_ready_o, .s_aw_id_i, .s_aw_addr_i, .s_aw_len_i, .s_aw_atop_i,
    .s_w_valid_i, .s_w_ready_o, .s_w_data_i, .s_w_last_i,
    .s_b_valid_o, .s_b_ready_i, .s_b_id_o, .s_b_resp_o,
    .s_r_valid_o, .s_r_ready_i, .s_r_id_o, .s_r_data_o, .s_r_resp_o, .s_r_last_o,
    .m_aw_valid_o, .m_aw_ready_i, .m_aw_id_o, .m_aw_addr_o, .m_aw_len_o,
    .m_w_valid_o, .m_w_ready_i, .m_w_data_o, .m_w_last_o,
    .m_b_valid_i, .m_b_ready_o, .m_b_id_i, .m_b_resp_i,
    .m_r_valid_i, .m_r_ready_o, .m_r_id_i, .m_r_data_i, .m_r_resp_i, .m_r_last_i
  );

  always @(negedge clk_i) begin
    if (rst_n) begin
      if (m_aw_valid_o && m_aw_ready_i) dn_aw_cnt++;
      if (m_w_valid_o && m_w_ready_i) dn_w_cnt++;
      if (s_b_valid_o && s_b_ready_i) up_b_cnt++;
      if (s_r_valid_o && s_r_ready_i) up_r_cnt++;
    end
  end

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
  endtask

  // Next drive point, 1 ns after the rising edge
  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk_i);
    #1;
  endtask

  task automatic send_aw(input id_t id, input addr_t addr, input len_t len,
                         input atop_t atop, input logic exp_down);
    int n;
    n = 0;
    s_aw_valid_i = 1'b1;
    s_aw_id_i    = id;
    s_aw_addr_i  = addr;
    s_aw_len_i   = len;
    s_aw_atop_i  = atop;
    @(negedge clk_i);
    while (!s_aw_ready_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!s_aw_ready_o) begin
      note_timeout("upstream AW ready");
    end else begin
      if (m_aw_valid_o !== exp_down) report_mismatch("downstream AW valid");
      if (exp_down && (m_aw_id_o !== id || m_aw_addr_o !== addr || m_aw_len_o !== len))
        report_mismatch("downstream AW id, addr or len");
    end
    idle(1);
    s_aw_valid_i = 1'b0;
  endtask

  // One W burst of len+1 beats with random data
  task automatic send_w(input len_t len, input logic exp_down);
    int n;
    for (int i = 0; i <= int'(len); i++) begin
      n = 0;
      s_w_valid_i = 1'b1;
      s_w_data_i  = data_t'($urandom);
      s_w_last_i  = (i == int'(len));
      @(negedge clk_i);
      while (!s_w_ready_o && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
      end
      if (!s_w_ready_o) begin
        note_timeout("upstream W ready");
      end else begin
        if (m_w_valid_o !== exp_down) report_mismatch("downstream W valid");
        if (exp_down && (m_w_data_o !== s_w_data_i || m_w_last_o !== s_w_last_i))
          report_mismatch("downstream W data or last");
      end
      idle(1);
    end
    s_w_valid_i = 1'b0;
    s_w_last_i  = 1'b0;
  endtask

  // Upstream ready stays low for one cycle, so the beat has to wait
  task automatic recv_b(input id_t exp_id, input resp_e exp_resp,
                        input logic exp_dn_ready);
    int n;
    n = 0;
    s_b_ready_i = 1'b0;
    @(negedge clk_i);
    while (!s_b_valid_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!s_b_valid_o) begin
      note_timeout("upstream B valid");
    end else begin
      if (m_b_ready_o !== 1'b0) report_mismatch("downstream B ready while upstream B stalled");
      idle(1);
      s_b_ready_i = 1'b1;
      @(negedge clk_i);
      if (s_b_valid_o !== 1'b1 || s_b_id_o !== exp_id || s_b_resp_o !== exp_resp) begin
        report_mismatch($sformatf("B valid %0b id %0h resp %0d, expected %0h %0d",
                                  s_b_valid_o, s_b_id_o, s_b_resp_o, exp_id, exp_resp));
      end
      if (m_b_ready_o !== exp_dn_ready) report_mismatch("downstream B ready");
    end
    idle(1);
    s_b_ready_i = 1'b1;
    m_b_valid_i = 1'b0;
  endtask

  task automatic recv_r(input id_t exp_id, input data_t exp_data, input resp_e exp_resp,
                        input logic exp_last, input logic exp_dn_ready);
    int n;
    n = 0;
    s_r_ready_i = 1'b1;
    @(negedge clk_i);
    while (!s_r_valid_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!s_r_valid_o) begin
      note_timeout("upstream R valid");
    end else begin
      if (s_r_id_o !== exp_id || s_r_data_o !== exp_data ||
          s_r_resp_o !== exp_resp || s_r_last_o !== exp_last) begin
        report_mismatch($sformatf("R beat id %0h data %0h resp %0d last %0b",
                                  s_r_id_o, s_r_data_o, s_r_resp_o, s_r_last_o));
      end
      if (m_r_ready_o !== exp_dn_ready) report_mismatch("downstream R ready");
    end
    idle(1);
    m_r_valid_i = 1'b0;
  endtask

  task automatic test_normal_write();
    id_t b_id;
    int  aw0, w0, b0;
    b_id = id_t'($urandom);
    aw0  = dn_aw_cnt;
    w0   = dn_w_cnt;
    b0   = up_b_cnt;
    send_aw(id_t'($urandom), addr_t'($urandom), 8'd1, ATOP_PLAIN, 1'b1);
    send_w(8'd1, 1'b1);
    // Slave answers with its own B
    m_b_valid_i = 1'b1;
    m_b_id_i    = b_id;
    m_b_resp_i  = RESP_OKAY;
    recv_b(b_id, RESP_OKAY, 1'b1);
    idle(4);
    if (dn_aw_cnt - aw0 != 1 || dn_w_cnt - w0 != 2 || up_b_cnt - b0 != 1)
      report_mismatch("normal write handshake counts");
  endtask

  task automatic test_atomic_store();
    id_t a_id;
    int  aw0, w0, b0, r0;
    a_id = id_t'($urandom);
    aw0  = dn_aw_cnt;
    w0   = dn_w_cnt;
    b0   = up_b_cnt;
    r0   = up_r_cnt;
    // Slave not ready, absorbed beats go in anyway
    m_w_ready_i = 1'b0;
    send_aw(a_id, addr_t'($urandom), 8'd1, ATOP_STORE, 1'b0);
    send_w(8'd1, 1'b0);
    m_w_ready_i = 1'b1;
    recv_b(a_id, RESP_SLVERR, 1'b0);
    idle(6);
    if (dn_aw_cnt != aw0 || dn_w_cnt != w0) report_mismatch("atomic store reached downstream");
    if (up_b_cnt - b0 != 1 || up_r_cnt != r0) report_mismatch("atomic store response counts");
  endtask

  task automatic test_atomic_load();
    id_t   a_id, r_id;
    data_t r_data;
    int    aw0, b0, r0;
    a_id   = id_t'($urandom);
    r_id   = id_t'($urandom);
    r_data = data_t'($urandom);
    aw0    = dn_aw_cnt;
    b0     = up_b_cnt;
    r0     = up_r_cnt;
    // Downstream R beat stuck behind a low upstream ready
    s_r_ready_i = 1'b0;
    m_r_valid_i = 1'b1;
    m_r_id_i    = r_id;
    m_r_data_i  = r_data;
    m_r_resp_i  = RESP_OKAY;
    m_r_last_i  = 1'b1;
    send_aw(a_id, addr_t'($urandom), 8'd2, ATOP_LOAD, 1'b0);
    send_w(8'd2, 1'b0);
    recv_b(a_id, RESP_SLVERR, 1'b0);
    // Held beat still offered upstream, slave sees no ready
    @(negedge clk_i);
    if (s_r_valid_o !== 1'b1 || s_r_id_o !== r_id || m_r_ready_o !== 1'b0)
      report_mismatch("downstream R beat not held while upstream R stalled");
    idle(1);
    recv_r(r_id, r_data, RESP_OKAY, 1'b1, 1'b1);
    for (int i = 0; i < 3; i++) begin
      recv_r(a_id, '0, RESP_SLVERR, i == 2, 1'b0);
    end
    idle(6);
    if (up_r_cnt - r0 != 4 || up_b_cnt - b0 != 1 || dn_aw_cnt != aw0)
      report_mismatch("atomic load response counts");
  endtask

  task automatic test_outstanding_limit();
    addr_t addr;
    int    aw0;
    aw0 = dn_aw_cnt;
    for (int i = 0; i < `ATOP_MAX_WRITE_TXNS; i++) begin
      send_aw(id_t'($urandom), addr_t'($urandom), 8'd0, ATOP_PLAIN, 1'b1);
    end
    // One more AW has to stall at the limit
    addr = addr_t'($urandom);
    s_aw_valid_i = 1'b1;
    s_aw_id_i    = id_t'(1);
    s_aw_addr_i  = addr;
    s_aw_len_i   = 8'd0;
    s_aw_atop_i  = ATOP_PLAIN;
    repeat (5) begin
      @(negedge clk_i);
      if (s_aw_ready_o) report_mismatch("AW accepted beyond the outstanding limit");
    end
    idle(1);
    send_w(8'd0, 1'b1);
    send_aw(id_t'(1), addr, 8'd0, ATOP_PLAIN, 1'b1);
    if (dn_aw_cnt - aw0 != `ATOP_MAX_WRITE_TXNS + 1) report_mismatch("AW count at the limit");
    // Drain what is left
    for (int i = 0; i < `ATOP_MAX_WRITE_TXNS; i++) begin
      send_w(8'd0, 1'b1);
    end
  endtask

  task automatic test_atomic_behind_pending();
    id_t a_id;
    int  aw0, w0, b0;
    a_id = id_t'($urandom);
    aw0  = dn_aw_cnt;
    w0   = dn_w_cnt;
    b0   = up_b_cnt;
    send_aw(id_t'($urandom), addr_t'($urandom), 8'd1, ATOP_PLAIN, 1'b1);
    send_aw(id_t'($urandom), addr_t'($urandom), 8'd1, ATOP_PLAIN, 1'b1);
    send_aw(a_id, addr_t'($urandom), 8'd1, ATOP_STORE, 1'b0);
    send_w(8'd1, 1'b1);
    send_w(8'd1, 1'b1);
    // Third burst belongs to the atomic
    m_w_ready_i = 1'b0;
    send_w(8'd1, 1'b0);
    m_w_ready_i = 1'b1;
    recv_b(a_id, RESP_SLVERR, 1'b0);
    send_aw(id_t'($urandom), addr_t'($urandom), 8'd1, ATOP_PLAIN, 1'b1);
    send_w(8'd1, 1'b1);
    idle(4);
    if (dn_aw_cnt - aw0 != 3 || dn_w_cnt - w0 != 6 || up_b_cnt - b0 != 1)
      report_mismatch("atomic behind pending writes counts");
  endtask

  initial begin
    int n;
    int unsigned asrt;
    n = 0;
    void'($urandom(22176));
    s_aw_valid_i = 1'b0;
    s_aw_id_i    = '0;
    s_aw_addr_i  = '0;
    s_aw_len_i   = '0;
    s_aw_atop_i  = '0;
    s_w_valid_i  = 1'b0;
    s_w_data_i   = '0;
    s_w_last_i   = 1'b0;
    s_b_ready_i  = 1'b1;
    s_r_ready_i  = 1'b1;
    m_aw_ready_i = 1'b1;
    m_w_ready_i  = 1'b1;
    m_b_valid_i  = 1'b0;
    m_b_id_i     = '0;
    m_b_resp_i   = RESP_OKAY;
    m_r_valid_i  = 1'b0;
    m_r_id_i     = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = RESP_OKAY;
    m_r_last_i   = 1'b0;
    // Outputs during reset
    @(negedge clk_i);
    if (s_aw_ready_o || s_w_ready_o || s_b_valid_o || s_r_valid_o ||
        m_aw_valid_o || m_w_valid_o)
      report_mismatch("handshake outputs not low in reset");
    while (!rst_n && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (!rst_n) note_timeout("reset release");
    #1;
    test_normal_write();
    test_atomic_store();
    test_atomic_load();
    test_outstanding_limit();
    test_atomic_behind_pending();
    asrt = uut.u_chk.fail_cnt;
    $display("Summary: %0d check errors, %0d timeouts, %0d assertion failures",
             errors, timeouts, asrt);
    if (errors == 0 && timeouts == 0 && asrt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end
endmodule

// File: files.f
+incdir+.
atop_pkg.sv
err_cmd_if.sv
w_burst_tracker.sv
write_ctrl.sv
r_err_gen.sv
resp_arbiter.sv
atop_filter_top.sv
atop_filter_chk.sv
tb_clk_gen.sv
tb_atop_filter.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ATOP filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_atop_filter -o Vtb_atop_filter; then
  echo "Verilator build failed"
  exit 1
fi

# Raised error limit lets the testbench reach its own summary
if ! sim_out=$(./obj_dir/Vtb_atop_filter +verilator+error+limit+100 2>&1); then
  echo "$sim_out"
  echo "Simulation exited with an error status"
  exit 1
fi
echo "$sim_out"

if grep -qx "TB PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1
